// File: Bender.yml
package:
  name: parser_stage

sources:
  - rtl/parser_pkg.sv
  - rtl/field_extract.sv
  - rtl/rule_table.sv
  - rtl/type_lookup.sv
  - rtl/phv_assemble.sv
  - rtl/parser_stage.sv
  - target: test
    files:
      - testbench/tb_parser_stage.sv

// File: rtl/field_extract.sv
/*
 * field_extract
 * decode part of the parser stage: moves the window so the
 * current header sits at byte 0, then pulls the 16-bit type
 * and length fields out of the header
 */

`timescale 1ns/100ps

module field_extract (
	input  logic                clk,
	input  logic                reset,
	input  parser_pkg::phv_t    phv_i,
	input  logic                valid_i,
	output parser_pkg::fields_t fields_o,
	output logic                valid_o
);
	import parser_pkg::*;

	pars_data_t win_q;
	pars_data_t data_q;
	byte_off_t  off_q;
	type_ctl_t  type_ctl_q;
	len_ctl_t   len_ctl_q;
	logic       valid_q;

	// 16 bits starting at a byte offset, zero past the end of the window
	function automatic field16_t take16(pars_data_t win, hdr_off_t off);
		pars_data_t moved;
		moved = win << {off, 3'b000};
		return moved[PARS_W-1 -: 16];
	endfunction

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

	// cycle 1: header to the top of the window, zero fill
	always_ff @(posedge clk) begin
		win_q      <= phv_i.pars_data << {phv_i.pars_off, 3'b000};
		data_q     <= phv_i.pars_data;
		off_q      <= phv_i.pars_off;
		type_ctl_q <= phv_i.type_ctl;
		len_ctl_q  <= phv_i.len_ctl;
	end

	// cycle 2: field extraction from the moved window
	always_ff @(posedge clk) begin
		if (type_ctl_q.valid) begin
			fields_o.type_fld <= take16(win_q, type_ctl_q.off);
		end else begin
			fields_o.type_fld <= '0;
		end
		fields_o.len_fld   <= take16(win_q, len_ctl_q.off);
		fields_o.pars_off  <= off_q;
		fields_o.len_ctl   <= len_ctl_q;
		// original window travels on, next_off is absolute
		fields_o.pars_data <= data_q;
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (!reset)
		!$isunknown(valid_o)
	);

endmodule

// File: rtl/parser_pkg.sv
/*
 * parser stage package
 * widths, rule and PHV structs, and the pipeline constants
 * shared by the decode, execute and result parts of the stage
 */

package parser_pkg;

	// window and rule table geometry
	localparam int PARS_W       = 512;
	localparam int NUM_RULE     = 8;
	localparam int RULE_ADDR_W  = 3;
	// cycles from phv_in_valid_i to phv_out_valid_o
	localparam int PIPE_LATENCY = 5;

	typedef logic [7:0]        byte_off_t;
	typedef logic [6:0]        hdr_off_t;
	typedef logic [15:0]       field16_t;
	typedef logic [31:0]       action_t;
	typedef logic [PARS_W-1:0] pars_data_t;

	// type field location, 8 bits
	typedef struct packed {
		logic     valid;
		hdr_off_t off;
	} type_ctl_t;

	// length field location and how to turn it into a byte count
	typedef struct packed {
		logic       calc;
		hdr_off_t   off;
		logic [7:0] mask;
		// fixed length, or shift amount in bits 1:0 when calc is set
		logic [7:0] val;
	} len_ctl_t;

	// byte 0 of pars_data is the most significant byte
	typedef struct packed {
		byte_off_t  pars_off;
		type_ctl_t  type_ctl;
		len_ctl_t   len_ctl;
		pars_data_t pars_data;
	} phv_t;

	typedef struct packed {
		logic     valid;
		field16_t key;
		field16_t mask;
		action_t  action;
	} rule_t;

	typedef rule_t [NUM_RULE-1:0] rule_arr_t;

	// decode to execute
	typedef struct packed {
		field16_t   type_fld;
		field16_t   len_fld;
		byte_off_t  pars_off;
		len_ctl_t   len_ctl;
		pars_data_t pars_data;
	} fields_t;

	// execute to result and out of the stage
	typedef struct packed {
		byte_off_t  next_off;
		logic       hit;
		action_t    action;
		field16_t   type_fld;
		pars_data_t pars_data;
	} result_t;

endpackage

// File: rtl/parser_stage.sv
/*
 * parser_stage
 * one stage of the header parser: decode, type lookup and
 * result register around a configurable rule table
 */

`timescale 1ns/100ps

module parser_stage (
	input  logic                               clk,
	input  logic                               reset,
	input  parser_pkg::phv_t                   phv_in_i,
	input  logic                               phv_in_valid_i,
	input  logic                               rule_wr_i,
	input  logic                               rule_rd_i,
	input  logic [parser_pkg::RULE_ADDR_W-1:0] rule_addr_i,
	input  parser_pkg::rule_t                  rule_data_i,
	output parser_pkg::result_t                phv_out_o,
	output logic                               phv_out_valid_o,
	output parser_pkg::rule_t                  rule_rdata_o,
	output logic                               rule_rvalid_o
);
	import parser_pkg::*;

	fields_t   fields;
	logic      fields_valid;
	result_t   result;
	logic      result_valid;
	rule_arr_t rules;

	field_extract u_decode (
		.clk      (clk),
		.reset    (reset),
		.phv_i    (phv_in_i),
		.valid_i  (phv_in_valid_i),
		.fields_o (fields),
		.valid_o  (fields_valid)
	);

	rule_table u_rules (
		.clk           (clk),
		.reset         (reset),
		.rule_wr_i     (rule_wr_i),
		.rule_rd_i     (rule_rd_i),
		.rule_addr_i   (rule_addr_i),
		.rule_data_i   (rule_data_i),
		.rule_rdata_o  (rule_rdata_o),
		.rule_rvalid_o (rule_rvalid_o),
		.rules_o       (rules)
	);

	type_lookup u_execute (
		.clk      (clk),
		.reset    (reset),
		.fields_i (fields),
		.valid_i  (fields_valid),
		.rules_i  (rules),
		.result_o (result),
		.valid_o  (result_valid)
	);

	phv_assemble u_result (
		.clk             (clk),
		.reset           (reset),
		.result_i        (result),
		.valid_i         (result_valid),
		.phv_out_o       (phv_out_o),
		.phv_out_valid_o (phv_out_valid_o)
	);

endmodule

// File: rtl/phv_assemble.sv
/*
 * phv_assemble
 * result part: registered output boundary of the stage,
 * holds the last result between valid cycles
 */

`timescale 1ns/100ps

module phv_assemble (
	input  logic                clk,
	input  logic                reset,
	input  parser_pkg::result_t result_i,
	input  logic                valid_i,
	output parser_pkg::result_t phv_out_o,
	output logic                phv_out_valid_o
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phv_out_valid_o <= 1'b0;
		end else begin
			phv_out_valid_o <= valid_i;
		end
	end

	// payload only moves with a valid result
	always_ff @(posedge clk) begin
		if (valid_i) begin
			phv_out_o <= result_i;
		end
	end

endmodule

// File: rtl/rule_table.sv
/*
 * rule_table
 * eight ternary type rules, written and read back over the
 * configuration port, all entries exposed for the parallel match
 */

`timescale 1ns/100ps

module rule_table (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               rule_wr_i,
	input  logic                               rule_rd_i,
	input  logic [parser_pkg::RULE_ADDR_W-1:0] rule_addr_i,
	input  parser_pkg::rule_t                  rule_data_i,
	output parser_pkg::rule_t                  rule_rdata_o,
	output logic                               rule_rvalid_o,
	output parser_pkg::rule_arr_t              rules_o
);
	import parser_pkg::*;

	logic [NUM_RULE-1:0] valid_q;
	field16_t            key_q [NUM_RULE];
	field16_t            mask_q [NUM_RULE];
	action_t             act_q [NUM_RULE];

	// valid bits are control state and clear on reset
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
		end else if (rule_wr_i) begin
			valid_q[rule_addr_i] <= rule_data_i.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rule_wr_i) begin
			key_q[rule_addr_i]  <= rule_data_i.key;
			mask_q[rule_addr_i] <= rule_data_i.mask;
			act_q[rule_addr_i]  <= rule_data_i.action;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_RULE; i++) begin
			rules_o[i].valid  = valid_q[i];
			rules_o[i].key    = key_q[i];
			rules_o[i].mask   = mask_q[i];
			rules_o[i].action = act_q[i];
		end
	end

	// read-back sees the contents before a same-cycle write
	always_ff @(posedge clk) begin
		if (rule_rd_i) begin
			rule_rdata_o <= rules_o[rule_addr_i];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rule_rvalid_o <= 1'b0;
		end else begin
			rule_rvalid_o <= rule_rd_i;
		end
	end

	a_rvalid_follows_rd: assert property (
		@(posedge clk) disable iff (!reset)
		rule_rvalid_o == $past(rule_rd_i)
	);

endmodule

// File: rtl/type_lookup.sv
/*
 * type_lookup
 * execute part: ternary match of the type field, priority
 * select of the highest hitting rule and next-header offset
 */

`timescale 1ns/100ps

module type_lookup (
	input  logic                  clk,
	input  logic                  reset,
	input  parser_pkg::fields_t   fields_i,
	input  logic                  valid_i,
	input  parser_pkg::rule_arr_t rules_i,
	output parser_pkg::result_t   result_o,
	output logic                  valid_o
);
	import parser_pkg::*;

	logic [NUM_RULE-1:0] hit_q;
	byte_off_t           len_q;
	fields_t             fields_q;
	logic                valid_q;
	action_t             sel_act;
	logic                sel_hit;
	byte_off_t           scaled;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

	// cycle 1: hit bitmap and masked length byte
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_RULE; i++) begin
			hit_q[i] <= rules_i[i].valid &&
				((fields_i.type_fld & rules_i[i].mask) == rules_i[i].key);
		end
		len_q    <= fields_i.len_fld[7:0] & fields_i.len_ctl.mask;
		fields_q <= fields_i;
	end

	// highest index wins, later iterations override earlier ones
	always_comb begin
		sel_act = '0;
		sel_hit = 1'b0;
		for (int i = 0; i < NUM_RULE; i++) begin
			if (hit_q[i]) begin
				sel_act = rules_i[i].action;
				sel_hit = 1'b1;
			end
		end
	end

	// length in units of 1, 2, 4 or 8 bytes
	assign scaled = len_q << fields_q.len_ctl.val[1:0];

	// cycle 2: select and offset add, wraps modulo 256
	always_ff @(posedge clk) begin
		if (fields_q.len_ctl.calc) begin
			result_o.next_off <= fields_q.pars_off + scaled;
		end else begin
			result_o.next_off <= fields_q.pars_off + fields_q.len_ctl.val;
		end
		result_o.hit       <= sel_hit;
		result_o.action    <= sel_act;
		result_o.type_fld  <= fields_q.type_fld;
		result_o.pars_data <= fields_q.pars_data;
	end

	a_valid_two_cycles: assert property (
		@(posedge clk) disable iff (!reset)
		valid_o == $past(valid_i, 2)
	);

endmodule

// File: sources.f
rtl/parser_pkg.sv
rtl/field_extract.sv
rtl/rule_table.sv
rtl/type_lookup.sv
rtl/phv_assemble.sv
rtl/parser_stage.sv
testbench/tb_parser_stage.sv

// File: testbench/tb_parser_stage.sv
/*
 * parser_stage testbench
 * rule table write and read-back, random and directed PHVs
 * against a reference model, checked by concurrent assertions
 */

`timescale 1ns/100ps

module tb_parser_stage;
	import parser_pkg::*;

	logic                   clk;
	logic                   reset;
	phv_t                   phv_in;
	logic                   phv_in_valid = 1'b0;
	logic                   rule_wr;
	logic                   rule_rd;
	logic [RULE_ADDR_W-1:0] rule_addr;
	rule_t                  rule_data;
	result_t                phv_out;
	logic                   phv_out_valid;
	rule_t                  rule_rdata;
	logic                   rule_rvalid;

	rule_t   rules_m [NUM_RULE];
	result_t exp_q [$];
	result_t exp_head;
	logic    exp_empty = 1'b1;
	rule_t   rd_exp;
	rule_t   rd_exp_q;
	int      seed = 39682;
	int      value_errs = 0;
	int      proto_errs = 0;

	parser_stage dut0 (
		.clk             (clk),
		.reset           (reset),
		.phv_in_i        (phv_in),
		.phv_in_valid_i  (phv_in_valid),
		.rule_wr_i       (rule_wr),
		.rule_rd_i       (rule_rd),
		.rule_addr_i     (rule_addr),
		.rule_data_i     (rule_data),
		.phv_out_o       (phv_out),
		.phv_out_valid_o (phv_out_valid),
		.rule_rdata_o    (rule_rdata),
		.rule_rvalid_o   (rule_rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// byte idx of a window, byte 0 at the top, zero past the end
	function automatic logic [7:0] win_byte(pars_data_t w, int idx);
		if (idx >= PARS_W / 8) begin
			return 8'h00;
		end
		return w[PARS_W - 1 - 8 * idx -: 8];
	endfunction

	// expected stage output for one PHV under the current rules
	function automatic result_t model(phv_t p);
		result_t    r;
		logic [7:0] len;
		int         t;
		int         l;
		r = '0;
		t = p.pars_off + p.type_ctl.off;
		l = p.pars_off + p.len_ctl.off;
		if (p.type_ctl.valid) begin
			r.type_fld = {win_byte(p.pars_data, t), win_byte(p.pars_data, t + 1)};
		end
		// search from the top, first hit is the winner
		for (int i = NUM_RULE - 1; i >= 0; i--) begin
			if (!r.hit && rules_m[i].valid &&
					(r.type_fld & rules_m[i].mask) == rules_m[i].key) begin
				r.hit = 1'b1;
				r.action = rules_m[i].action;
			end
		end
		len = win_byte(p.pars_data, l + 1) & p.len_ctl.mask;
		if (p.len_ctl.calc) begin
			r.next_off = (p.pars_off + len * (1 << p.len_ctl.val[1:0])) % 256;
		end else begin
			r.next_off = (p.pars_off + p.len_ctl.val) % 256;
		end
		r.pars_data = p.pars_data;
		return r;
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic refresh_head();
		exp_empty = (exp_q.size() == 0);
		if (!exp_empty) begin
			exp_head = exp_q[0];
		end
	endtask

	task automatic send(phv_t p);
		phv_in = p;
		phv_in_valid = 1'b1;
		exp_q.push_back(model(p));
		refresh_head();
		step();
		phv_in_valid = 1'b0;
	endtask

	task automatic rand_phv(output phv_t p);
		for (int i = 0; i < PARS_W / 32; i++) begin
			p.pars_data[32 * i +: 32] = $random(seed);
		end
		// a few offsets land past the end of the window
		p.pars_off = {$random(seed)} % 72;
		p.type_ctl = $random(seed);
		p.type_ctl.off = {$random(seed)} % 32;
		p.len_ctl = $random(seed);
		p.len_ctl.off = {$random(seed)} % 32;
	endtask

	// type value placed two bytes into the header
	task automatic send_type(field16_t t);
		phv_t p;
		rand_phv(p);
		p.pars_off = {$random(seed)} % 60;
		p.type_ctl = {1'b1, 7'd2};
		p.pars_data[PARS_W - 1 - 8 * (p.pars_off + 2) -: 16] = t;
		send(p);
	endtask

	task automatic write_rule(int a, rule_t r);
		rule_wr = 1'b1;
		rule_addr = RULE_ADDR_W'(a);
		rule_data = r;
		rules_m[a] = r;
		step();
		rule_wr = 1'b0;
	endtask

	task automatic read_rule(int a);
		int n;
		rule_rd = 1'b1;
		rule_addr = RULE_ADDR_W'(a);
		rd_exp = rules_m[a];
		step();
		rule_rd = 1'b0;
		n = 0;
		while (!rule_rvalid && n < 4) begin
			step();
			n++;
		end
		if (!rule_rvalid) begin
			$display("timeout: no read-back for rule %0d", a);
			proto_errs++;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			step();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d PHVs never came out", exp_q.size());
			proto_errs++;
			exp_q.delete();
			refresh_head();
		end
	endtask

	task automatic report_mismatch(result_t got, result_t exp);
		value_errs++;
		if (got.next_off != exp.next_off)
			$display("FAILED %0t phv_out_o.next_off got %h expected %h",
				$time, got.next_off, exp.next_off);
		if (got.hit != exp.hit)
			$display("FAILED %0t phv_out_o.hit got %b expected %b", $time, got.hit, exp.hit);
		if (got.action != exp.action)
			$display("FAILED %0t phv_out_o.action got %h expected %h",
				$time, got.action, exp.action);
		if (got.type_fld != exp.type_fld)
			$display("FAILED %0t phv_out_o.type_fld got %h expected %h",
				$time, got.type_fld, exp.type_fld);
		if (got.pars_data != exp.pars_data)
			$display("FAILED %0t phv_out_o.pars_data got %h expected %h",
				$time, got.pars_data, exp.pars_data);
	endtask

	// retire the head once its output has been checked
	always @(posedge clk) begin
		if (reset && phv_out_valid && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	always @(posedge clk) begin
		rd_exp_q <= rd_exp;
	end

	a_reset_idle: assert property (@(posedge clk)
		!reset && $past(!reset) |-> !phv_out_valid && !rule_rvalid)
		else begin
			proto_errs++;
			$display("output valid flag set during reset at %0t", $time);
		end

	a_no_stray_out: assert property (@(posedge clk) disable iff (!reset)
		phv_out_valid |-> !exp_empty)
		else begin
			proto_errs++;
			$display("output valid at %0t with no PHV outstanding", $time);
		end

	a_latency: assert property (@(posedge clk) disable iff (!reset)
		phv_out_valid == $past(phv_in_valid, PIPE_LATENCY))
		else begin
			proto_errs++;
			$display("output valid not %0d cycles after input at %0t", PIPE_LATENCY, $time);
		end

	a_out_match: assert property (@(posedge clk) disable iff (!reset)
		phv_out_valid && !exp_empty |-> phv_out == exp_head)
		else report_mismatch($sampled(phv_out), $sampled(exp_head));

	a_rvalid_timing: assert property (@(posedge clk) disable iff (!reset)
		rule_rvalid == $past(rule_rd))
		else begin
			proto_errs++;
			$display("rule_rvalid_o not one cycle after rule_rd_i at %0t", $time);
		end

	a_rdata: assert property (@(posedge clk) disable iff (!reset)
		rule_rvalid |-> rule_rdata == rd_exp_q)
		else begin
			value_errs++;
			$display("FAILED %0t rule_rdata_o got %h expected %h",
				$time, $sampled(rule_rdata), $sampled(rd_exp_q));
		end

	initial begin
		phv_t  p;
		rule_t r;
		reset = 1'b0;
		phv_in = '0;
		phv_in_valid = 1'b0;
		rule_wr = 1'b0;
		rule_rd = 1'b0;
		rule_addr = '0;
		rule_data = '0;
		rd_exp = '0;
		for (int i = 0; i < NUM_RULE; i++) begin
			rules_m[i] = '0;
		end
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b1;

		// empty table, no hit
		rand_phv(p);
		send(p);
		drain();

		// table write and read-back
		for (int a = 0; a < NUM_RULE; a++) begin
			r = {1'b1, 16'($random(seed)), 16'($random(seed)), 32'($random(seed))};
			write_rule(a, r);
		end
		for (int a = 0; a < NUM_RULE; a++) begin
			read_rule(a);
		end

		// back to back random PHVs
		repeat (24) begin
			rand_phv(p);
			send(p);
		end
		drain();

		// overlapping rules, 2, 6 and 7 invalid
		write_rule(0, {1'b1, 16'h0000, 16'h0000, 32'h0000_00a0});
		write_rule(1, {1'b1, 16'h0800, 16'hffff, 32'h0000_00a1});
		write_rule(2, {1'b0, 16'h0800, 16'hffff, 32'h0000_00a2});
		write_rule(3, {1'b1, 16'h0800, 16'hff00, 32'h0000_00a3});
		write_rule(4, {1'b1, 16'h1234, 16'hffff, 32'h0000_00a4});
		write_rule(5, {1'b1, 16'h86dd, 16'hffff, 32'h0000_00a5});
		write_rule(6, {1'b0, 16'h0800, 16'hff00, 32'h0000_00a6});
		write_rule(7, {1'b0, 16'h0000, 16'h0000, 32'h0000_00a7});
		send_type(16'h0800);
		send_type(16'h0812);
		send_type(16'h1234);
		send_type(16'h86dd);
		send_type(16'h5555);
		drain();

		// fixed and calculated lengths, all shifts, with wrap
		for (int s = 0; s < 8; s++) begin
			rand_phv(p);
			p.pars_off = 8'd40 + 8'(2 * s);
			p.len_ctl.calc = s[2];
			p.len_ctl.off = 7'd4;
			p.len_ctl.mask = s[0] ? 8'h0f : 8'hff;
			p.len_ctl.val = s[2] ? 8'(s[1:0]) : 8'hf0 + 8'(s);
			p.pars_data[PARS_W - 1 - 8 * (p.pars_off + 5) -: 8] = 8'hff;
			send(p);
		end
		drain();

		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
